// File: compile.f
+incdir+common
common/rv32i_mem_pkg.sv
rtl/pipe_stage_reg.sv
rtl/mem_stage.sv
rtl/data_mem.sv
rtl/load_align.sv
rtl/mem_fwd_ctrl.sv
rtl/mem_subsys_top.sv
sim/mem_subsys_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= mem_subsys_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/mem_subsys_tb.sv
// testbench for the memory access subsystem: byte reference memory, directed tests, timeout
`timescale 1ns/1ps
`include "rv32i_mem_cfg.svh"

module mem_subsys_tb;

    // the tests take about 130 cycles, the limit leaves ample margin
    localparam int max_cycles = 400;
    localparam int depth = 1 << `DMEM_ADDR_W;

    logic        clk = 1'b0;
    logic        reset;
    logic        stall;
    logic        ex_valid;
    logic [2:0]  ex_funct3;
    logic        ex_is_load;
    logic        ex_is_store;
    logic        ex_writes_rd;
    logic [4:0]  ex_rd;
    logic [4:0]  ex_rs2_idx;
    logic [31:0] ex_rs2_data;
    logic [31:0] ex_alu_out;
    logic        wb_valid;
    logic        wb_writes_rd;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    // byte-addressed memory model, expected write-backs as {writes_rd, rd, data}
    logic [7:0]  ref_mem [int unsigned];
    logic [37:0] exp_q [$];
    logic [37:0] exp_wb;
    logic        prev_stall = 1'b0;
    int          errors = 0;
    int          wb_count = 0;
    int          cycles = 0;
    int          write_count = 0;
    // most recently issued instruction, source of store forwarding
    logic        last_valid = 1'b0;
    logic        last_writes = 1'b0;
    logic [4:0]  last_rd = 5'd0;
    logic [31:0] last_value = 32'd0;

    mem_subsys_top u_dut (.*);

    always #2 clk = ~clk;

    // stall as seen by the DUT at the last edge
    always @(posedge clk)
    begin
        prev_stall <= stall;
        if (u_dut.mem_write_en)
        begin
            write_count++;
        end
        cycles++;
        if (cycles >= max_cycles)
        begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic check(input string what, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected)
        begin
            errors++;
            $display("MISMATCH time=%0t %s: got %h expected %h", $time, what, actual, expected);
        end
    endtask

    // a held wb_valid under stall is the same instruction
    always @(negedge clk)
    begin
        if (!reset && wb_valid && !prev_stall)
        begin
            if (exp_q.size() == 0)
            begin
                errors++;
                $display("unexpected write-back at time %0t with nothing outstanding", $time);
            end
            else
            begin
                exp_wb = exp_q.pop_front();
                wb_count++;
                check("wb_writes_rd", 32'(wb_writes_rd), 32'(exp_wb[37]));
                check("wb_rd", 32'(wb_rd), 32'(exp_wb[36:32]));
                if (exp_wb[37])
                begin
                    check("wb_data", wb_data, exp_wb[31:0]);
                end
            end
        end
    end

    task automatic write_ref_mem(input logic [2:0] f3, input logic [31:0] addr,
                                 input logic [31:0] data);
        int unsigned base;
        base = {addr[31:2], 2'b00};
        case (f3)
            rv32i_mem_pkg::sb:
            begin
                ref_mem[addr] = data[7:0];
            end
            rv32i_mem_pkg::sh:
            begin
                // lanes 0-1 for offsets 0 and 1, lanes 2-3 otherwise
                base = base + (addr[1] ? 2 : 0);
                ref_mem[base] = data[7:0];
                ref_mem[base + 1] = data[15:8];
            end
            default:
            begin
                for (int i = 0; i < 4; i++)
                begin
                    ref_mem[base + i] = data[8*i +: 8];
                end
            end
        endcase
    endtask

    function automatic logic [31:0] read_ref_mem(input logic [2:0] f3, input logic [31:0] addr);
        int unsigned base;
        logic [7:0]  b;
        logic [15:0] h;
        base = {addr[31:2], 2'b00};
        b = ref_mem[addr];
        h = {ref_mem[base + (addr[1] ? 3 : 1)], ref_mem[base + (addr[1] ? 2 : 0)]};
        case (f3)
            rv32i_mem_pkg::lb:  return {{24{b[7]}}, b};
            rv32i_mem_pkg::lbu: return {24'b0, b};
            rv32i_mem_pkg::lh:  return {{16{h[15]}}, h};
            rv32i_mem_pkg::lhu: return {16'b0, h};
            default: return {ref_mem[base + 3], ref_mem[base + 2], ref_mem[base + 1], ref_mem[base]};
        endcase
    endfunction

    task automatic issue(input logic [2:0] f3, input logic is_ld, input logic is_st,
                         input logic wr, input logic [4:0] rd, input logic [4:0] rs2_idx,
                         input logic [31:0] rs2_data, input logic [31:0] alu_out);
        logic [31:0] sdata;
        logic [31:0] result;
        @(posedge clk);
        ex_valid     <= 1'b1;
        ex_funct3    <= f3;
        ex_is_load   <= is_ld;
        ex_is_store  <= is_st;
        ex_writes_rd <= wr;
        ex_rd        <= rd;
        ex_rs2_idx   <= rs2_idx;
        ex_rs2_data  <= rs2_data;
        ex_alu_out   <= alu_out;
        // store right behind the producer of its rs2 gets the write-back value
        sdata = rs2_data;
        if (is_st && last_valid && last_writes && last_rd != 5'd0 && last_rd == rs2_idx)
        begin
            sdata = last_value;
        end
        if (is_st)
        begin
            write_ref_mem(f3, alu_out, sdata);
        end
        result = is_ld ? read_ref_mem(f3, alu_out) : alu_out;
        exp_q.push_back({wr, rd, result});
        last_valid  = 1'b1;
        last_writes = wr;
        last_rd     = rd;
        last_value  = result;
    endtask

    task automatic alu_instr(input logic [4:0] rd, input logic [31:0] value);
        issue(3'b000, 1'b0, 1'b0, 1'b1, rd, 5'd0, 32'd0, value);
    endtask

    task automatic load_instr(input logic [2:0] f3, input logic [4:0] rd, input logic [31:0] addr);
        issue(f3, 1'b1, 1'b0, 1'b1, rd, 5'd0, 32'd0, addr);
    endtask

    task automatic store_instr(input logic [2:0] f3, input logic [4:0] rs2_idx,
                               input logic [31:0] data, input logic [31:0] addr);
        issue(f3, 1'b0, 1'b1, 1'b0, 5'd0, rs2_idx, data, addr);
    endtask

    task automatic idle();
        @(posedge clk);
        ex_valid <= 1'b0;
        last_valid = 1'b0;
    endtask

    task automatic drain();
        idle();
        while (exp_q.size() != 0)
        begin
            @(negedge clk);
        end
    endtask

    // freeze with whatever is in MEM and WB, a bubble follows the release
    task automatic hold_stall(input int n);
        @(posedge clk);
        stall    <= 1'b1;
        ex_valid <= 1'b0;
        repeat (n) @(posedge clk);
        stall <= 1'b0;
        last_valid = 1'b0;
    endtask

    task automatic reset_and_alu_pass();
        @(posedge clk);
        @(negedge clk);
        check("wb_valid during reset", 32'(wb_valid), 32'd0);
        @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check("wb_valid after reset", 32'(wb_valid), 32'd0);
        alu_instr(5'd3, 32'h1234_5678);
        idle();
        // sampled at the first edge, in write-back after the second
        @(negedge clk);
        check("wb_valid after first edge", 32'(wb_valid), 32'd0);
        @(negedge clk);
        check("wb_valid after second edge", 32'(wb_valid), 32'd1);
        alu_instr(5'd4, $urandom);
        alu_instr(5'd31, $urandom);
        drain();
    endtask

    task automatic word_round_trip();
        logic [31:0] addrs [8];
        for (int i = 0; i < 8; i++)
        begin
            addrs[i] = ($urandom % depth) << 2;
            store_instr(rv32i_mem_pkg::sw, 5'd2, $urandom, addrs[i]);
        end
        for (int i = 0; i < 8; i++)
        begin
            load_instr(rv32i_mem_pkg::lw, 5'(10 + i), addrs[i]);
        end
        drain();
    endtask

    task automatic partial_stores();
        logic [31:0] base;
        base = 32'h0000_0100;
        store_instr(rv32i_mem_pkg::sw, 5'd2, $urandom, base);
        for (int off = 0; off < 4; off++)
        begin
            store_instr(rv32i_mem_pkg::sb, 5'd2, $urandom, base + 32'(off));
            load_instr(rv32i_mem_pkg::lw, 5'd11, base);
            store_instr(rv32i_mem_pkg::sh, 5'd2, $urandom, base + 32'(off));
            load_instr(rv32i_mem_pkg::lw, 5'd11, base);
        end
        drain();
    endtask

    task automatic load_extension();
        logic [31:0] addr;
        addr = 32'h0000_0200;
        store_instr(rv32i_mem_pkg::sw, 5'd2, 32'hf38c_a5d1, addr);
        store_instr(rv32i_mem_pkg::sw, 5'd2, $urandom | 32'h8080_8080, addr + 32'd4);
        for (int i = 0; i < 8; i++)
        begin
            load_instr(rv32i_mem_pkg::lb, 5'd12, addr + 32'(i));
            load_instr(rv32i_mem_pkg::lbu, 5'd12, addr + 32'(i));
            load_instr(rv32i_mem_pkg::lh, 5'd12, addr + 32'(i));
            load_instr(rv32i_mem_pkg::lhu, 5'd12, addr + 32'(i));
        end
        drain();
    endtask

    task automatic store_forwarding();
        store_instr(rv32i_mem_pkg::sw, 5'd2, 32'hcafe_f00d, 32'h300);
        // x5 loaded, stale x5 in the store right behind it
        load_instr(rv32i_mem_pkg::lw, 5'd5, 32'h300);
        store_instr(rv32i_mem_pkg::sw, 5'd5, 32'hdead_beef, 32'h304);
        load_instr(rv32i_mem_pkg::lw, 5'd13, 32'h304);
        // x0 never forwards, so the stale value reaches memory
        load_instr(rv32i_mem_pkg::lw, 5'd0, 32'h300);
        store_instr(rv32i_mem_pkg::sw, 5'd0, 32'h0bad_0bad, 32'h308);
        load_instr(rv32i_mem_pkg::lw, 5'd13, 32'h308);
        drain();
    endtask

    task automatic stall_hold();
        int base_writes;
        alu_instr(5'd7, 32'h5a5a_1234);
        store_instr(rv32i_mem_pkg::sw, 5'd7, 32'h1111_1111, 32'h400);
        base_writes = write_count;
        hold_stall(5);
        drain();
        check("memory writes across stall", 32'(write_count - base_writes), 32'd1);
        load_instr(rv32i_mem_pkg::lw, 5'd14, 32'h400);
        drain();
    endtask

    initial
    begin
        void'($urandom(32'hbfa2f016));
        reset        = 1'b1;
        stall        = 1'b0;
        ex_valid     = 1'b0;
        ex_funct3    = 3'd0;
        ex_is_load   = 1'b0;
        ex_is_store  = 1'b0;
        ex_writes_rd = 1'b0;
        ex_rd        = 5'd0;
        ex_rs2_idx   = 5'd0;
        ex_rs2_data  = 32'd0;
        ex_alu_out   = 32'd0;
        reset_and_alu_pass();
        word_round_trip();
        partial_stores();
        load_extension();
        store_forwarding();
        stall_hold();
        $display("summary: %0d errors, %0d write-backs checked", errors, wb_count);
        if (errors == 0)
        begin
            $display("RESULT: PASS");
        end
        else
        begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: rtl/mem_subsys_top.sv
// memory access subsystem: EX/MEM and MEM/WB registers, MEM datapath, data RAM
`timescale 1ns/1ps
`include "rv32i_mem_cfg.svh"

module mem_subsys_top (
    input  logic        clk,
    input  logic        reset,
    input  logic        stall,
    input  logic        ex_valid,
    input  logic [2:0]  ex_funct3,
    input  logic        ex_is_load,
    input  logic        ex_is_store,
    input  logic        ex_writes_rd,
    input  logic [4:0]  ex_rd,
    input  logic [4:0]  ex_rs2_idx,
    input  logic [31:0] ex_rs2_data,
    input  logic [31:0] ex_alu_out,
    output logic        wb_valid,
    output logic        wb_writes_rd,
    output logic [4:0]  wb_rd,
    output logic [31:0] wb_data
);

    rv32i_mem_pkg::exmem_t   ex_payload;
    rv32i_mem_pkg::exmem_t   exmem;
    rv32i_mem_pkg::memwb_t   mem_payload;
    rv32i_mem_pkg::memwb_t   memwb;
    rv32i_mem_pkg::fwd_sel_t wdata_fwd_sel;

    logic        mem_valid;
    logic [1:0]  addr_offset;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [3:0]  mem_byte_enable;
    logic        mem_write_en;
    logic        mem_read_en;
    logic [31:0] ram_rdata;
    logic [31:0] load_data;

    assign ex_payload = '{funct3: ex_funct3, is_load: ex_is_load, is_store: ex_is_store,
                          writes_rd: ex_writes_rd, rd: ex_rd, rs2_idx: ex_rs2_idx,
                          rs2_data: ex_rs2_data, alu_out: ex_alu_out};

    pipe_stage_reg #(.payload_t(rv32i_mem_pkg::exmem_t)) u_exmem_reg (
        .clk(clk), .reset(reset), .stall(stall),
        .in_valid(ex_valid), .in_data(ex_payload),
        .out_valid(mem_valid), .out_data(exmem)
    );

    mem_stage u_mem_stage (
        .funct3(exmem.funct3), .rs2_data(exmem.rs2_data), .addr_in(exmem.alu_out),
        .wdata_fwd_sel(wdata_fwd_sel), .rs2_fwd(wb_data),
        .addr_offset(addr_offset), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_byte_enable(mem_byte_enable)
    );

    mem_fwd_ctrl u_fwd_ctrl (
        .stall(stall), .mem_valid(mem_valid), .mem_is_store(exmem.is_store),
        .mem_is_load(exmem.is_load), .mem_rs2_idx(exmem.rs2_idx),
        .wb_valid(wb_valid), .wb_writes_rd(wb_writes_rd), .wb_rd(wb_rd),
        .wdata_fwd_sel(wdata_fwd_sel), .mem_write_en(mem_write_en), .mem_read_en(mem_read_en)
    );

    // byte address bits above the offset select the word
    data_mem u_data_mem (
        .clk(clk), .reset(reset), .write_en(mem_write_en), .read_en(mem_read_en),
        .word_addr(mem_addr[`DMEM_ADDR_W+1:2]), .wdata(mem_wdata),
        .byte_enable(mem_byte_enable), .rdata(ram_rdata)
    );

    assign mem_payload = '{funct3: exmem.funct3, is_load: exmem.is_load,
                           writes_rd: exmem.writes_rd, rd: exmem.rd,
                           offset: addr_offset, alu_out: exmem.alu_out};

    pipe_stage_reg #(.payload_t(rv32i_mem_pkg::memwb_t)) u_memwb_reg (
        .clk(clk), .reset(reset), .stall(stall),
        .in_valid(mem_valid), .in_data(mem_payload),
        .out_valid(wb_valid), .out_data(memwb)
    );

    // RAM word arrives together with the MEM/WB payload
    load_align u_load_align (
        .funct3(memwb.funct3), .addr_offset(memwb.offset),
        .word(ram_rdata), .load_data(load_data)
    );

    // write-back value, also the forwarding source for stores
    assign wb_data      = memwb.is_load ? load_data : memwb.alu_out;
    assign wb_writes_rd = memwb.writes_rd;
    assign wb_rd        = memwb.rd;

endmodule

// File: rtl/mem_fwd_ctrl.sv
// MEM stage control with store data forwarding select and data memory enables
`timescale 1ns/1ps

module mem_fwd_ctrl (
    input  logic                    stall,
    input  logic                    mem_valid,
    input  logic                    mem_is_store,
    input  logic                    mem_is_load,
    input  logic [4:0]              mem_rs2_idx,
    input  logic                    wb_valid,
    input  logic                    wb_writes_rd,
    input  logic [4:0]              wb_rd,
    output rv32i_mem_pkg::fwd_sel_t wdata_fwd_sel,
    output logic                    mem_write_en,
    output logic                    mem_read_en
);

    logic store_in_mem;
    logic wb_produces;
    logic rs2_match;

    assign store_in_mem = mem_valid && mem_is_store;

    // x0 never forwards since it always reads as zero
    assign wb_produces = wb_valid && wb_writes_rd && (wb_rd != 5'd0);
    assign rs2_match   = (mem_rs2_idx == wb_rd);

    // store whose rs2 is being written back right now
    // usually a load right ahead of the store
    always_comb
    begin
        if (store_in_mem && wb_produces && rs2_match)
        begin
            wdata_fwd_sel = rv32i_mem_pkg::use_fwd;
        end
        else
        begin
            wdata_fwd_sel = rv32i_mem_pkg::use_reg;
        end
    end

    // no memory side effect while the pipe is frozen
    assign mem_write_en = store_in_mem && !stall;
    assign mem_read_en  = mem_valid && mem_is_load && !stall;

    // decode upstream must never flag one instruction as load and store
    always_comb
    begin
        enables_exclusive_a: assert (!(mem_write_en && mem_read_en));
    end

endmodule

// File: rtl/load_align.sv
// load extraction: picks byte, half or word by offset and extends it
`timescale 1ns/1ps

module load_align (
    input  logic [2:0]  funct3,
    input  logic [1:0]  addr_offset,
    input  logic [31:0] word,
    output logic [31:0] load_data
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    // byte lane chosen by the full offset
    always_comb
    begin
        case (addr_offset)
            2'b00:   byte_sel = word[7:0];
            2'b01:   byte_sel = word[15:8];
            2'b10:   byte_sel = word[23:16];
            default: byte_sel = word[31:24];
        endcase
    end

    // half chosen by offset bit 1 only, same rule as the store side
    always_comb
    begin
        if (addr_offset[1])
        begin
            half_sel = word[31:16];
        end
        else
        begin
            half_sel = word[15:0];
        end
    end

    // sign or zero extension per funct3
    always_comb
    begin
        case (rv32i_mem_pkg::load_funct3_t'(funct3))
            rv32i_mem_pkg::lb:
            begin
                load_data = {{24{byte_sel[7]}}, byte_sel};
            end
            rv32i_mem_pkg::lbu:
            begin
                load_data = {24'b0, byte_sel};
            end
            rv32i_mem_pkg::lh:
            begin
                load_data = {{16{half_sel[15]}}, half_sel};
            end
            rv32i_mem_pkg::lhu:
            begin
                load_data = {16'b0, half_sel};
            end
            default:
            begin
                // lw, and anything undecoded, returns the raw word
                load_data = word;
            end
        endcase
    end

endmodule

// File: rtl/data_mem.sv
// on-chip data RAM: byte lane writes, one cycle registered read
`timescale 1ns/1ps
`include "rv32i_mem_cfg.svh"

module data_mem (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    write_en,
    input  logic                    read_en,
    input  logic [`DMEM_ADDR_W-1:0] word_addr,
    input  logic [`RV_XLEN-1:0]     wdata,
    input  logic [3:0]              byte_enable,
    output logic [`RV_XLEN-1:0]     rdata
);

    localparam int depth = 1 << `DMEM_ADDR_W;

    logic [`RV_XLEN-1:0] mem [0:depth-1];

    // write each enabled lane, contents survive reset
    always_ff @(posedge clk)
    begin
        if (write_en && !reset)
        begin
            for (int lane = 0; lane < 4; lane++)
            begin
                if (byte_enable[lane])
                begin
                    mem[word_addr][8*lane +: 8] <= wdata[8*lane +: 8];
                end
            end
        end
    end

    // read word register, holds between loads
    always_ff @(posedge clk)
    begin
        if (read_en)
        begin
            rdata <= mem[word_addr];
        end
    end

    // a write with no lanes means mem_stage and the controller disagree
    write_has_lanes_a: assert property (
        @(posedge clk) disable iff (reset)
        write_en |-> (byte_enable != 4'b0000)
    );

endmodule

// File: rtl/mem_stage.sv
// MEM stage datapath: store data forwarding, lane alignment, byte enables
`timescale 1ns/1ps

module mem_stage (
    input  logic [2:0]             funct3,
    input  logic [31:0]            rs2_data,
    input  logic [31:0]            addr_in,
    input  rv32i_mem_pkg::fwd_sel_t wdata_fwd_sel,
    input  logic [31:0]            rs2_fwd,
    output logic [1:0]             addr_offset,
    output logic [31:0]            mem_addr,
    output logic [31:0]            mem_wdata,
    output logic [3:0]             mem_byte_enable
);

    logic [31:0] store_val;

    // word aligned address, byte offset goes on to write-back
    assign mem_addr    = {addr_in[31:2], 2'b00};
    assign addr_offset = addr_in[1:0];

    // forwarded write-back value replaces a stale rs2
    always_comb
    begin
        if (wdata_fwd_sel == rv32i_mem_pkg::use_fwd)
        begin
            store_val = rs2_fwd;
        end
        else
        begin
            store_val = rs2_data;
        end
    end

    // place data in its lanes and enable only those lanes
    always_comb
    begin
        mem_wdata       = store_val;
        mem_byte_enable = 4'b1111;
        case (rv32i_mem_pkg::store_funct3_t'(funct3))
            rv32i_mem_pkg::sb:
            begin
                case (addr_offset)
                    2'b00:
                    begin
                        mem_wdata       = {24'b0, store_val[7:0]};
                        mem_byte_enable = 4'b0001;
                    end
                    2'b01:
                    begin
                        mem_wdata       = {16'b0, store_val[7:0], 8'b0};
                        mem_byte_enable = 4'b0010;
                    end
                    2'b10:
                    begin
                        mem_wdata       = {8'b0, store_val[7:0], 16'b0};
                        mem_byte_enable = 4'b0100;
                    end
                    default:
                    begin
                        mem_wdata       = {store_val[7:0], 24'b0};
                        mem_byte_enable = 4'b1000;
                    end
                endcase
            end
            rv32i_mem_pkg::sh:
            begin
                // offset bit 0 is ignored, halves land on lanes 0-1 or 2-3
                if (addr_offset[1])
                begin
                    mem_wdata       = {store_val[15:0], 16'b0};
                    mem_byte_enable = 4'b1100;
                end
                else
                begin
                    mem_wdata       = {16'b0, store_val[15:0]};
                    mem_byte_enable = 4'b0011;
                end
            end
            default:
            begin
                // sw and unknown codes write the full word
                mem_wdata       = store_val;
                mem_byte_enable = 4'b1111;
            end
        endcase
    end

endmodule

// File: rtl/pipe_stage_reg.sv
// generic pipeline stage register: payload of any type plus a valid bit
`timescale 1ns/1ps

module pipe_stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     stall,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    // valid bit, cleared by reset, held while stalled
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            out_valid <= 1'b0;
        end
        else if (!stall)
        begin
            out_valid <= in_valid;
        end
    end

    // payload, only meaningful when out_valid is set
    always_ff @(posedge clk)
    begin
        if (!stall)
        begin
            out_data <= in_data;
        end
    end

    // once out of reset the valid bit must stay defined,
    // a stray X would leak into the memory enables
    valid_known_a: assert property (
        @(posedge clk) disable iff (reset)
        !$isunknown(out_valid)
    );

endmodule

// File: common/rv32i_mem_pkg.sv
// shared types: store and load funct3 codes, forwarding select, EX/MEM and MEM/WB payloads
`include "rv32i_mem_cfg.svh"

package rv32i_mem_pkg;

    // store funct3 field, RV32I encodings
    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3_t;

    // load funct3 field, unsigned variants have bit 2 set
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_t;

    // source of store data in MEM
    typedef enum logic {
        use_reg = 1'b0,
        use_fwd = 1'b1
    } fwd_sel_t;

    // instruction held between execute and memory
    typedef struct packed {
        logic [2:0]            funct3;
        logic                  is_load;
        logic                  is_store;
        logic                  writes_rd;
        logic [4:0]            rd;
        logic [4:0]            rs2_idx;
        logic [`RV_XLEN-1:0]   rs2_data;
        logic [`RV_XLEN-1:0]   alu_out;
    } exmem_t;

    // instruction held between memory and write-back
    typedef struct packed {
        logic [2:0]            funct3;
        logic                  is_load;
        logic                  writes_rd;
        logic [4:0]            rd;
        logic [1:0]            offset;
        logic [`RV_XLEN-1:0]   alu_out;
    } memwb_t;

endpackage

// File: common/rv32i_mem_cfg.svh
// configuration macros: data path width and data memory depth
`ifndef RV32I_MEM_CFG_SVH
`define RV32I_MEM_CFG_SVH

// register and memory word width in bits
// the lane logic assumes four byte lanes
`define RV_XLEN 32

// log2 of the data memory depth in words
// 10 gives 1024 words, 4 KiB
// any depth works, the word address is cut from the
// byte address above bit 1
`define DMEM_ADDR_W 10

`endif
